// File: flist.f
logic/snd_map_pkg.sv
logic/snd_stream_pkg.sv
logic/voice_regs.sv
logic/fetch_sequencer.sv
logic/voice_mixer.sv
logic/sound_core.sv
verification/sound_core_tb.sv

// File: logic/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer #(
	parameter int voice_count = 4
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          en,
	input  snd_stream_pkg::voice_fetch_t [voice_count-1:0] voices,
	input  logic [7:0]                                    rom_data,
	input  logic                                          rom_ready,
	output logic                                          rom_load,
	output logic [23:0]                                   rom_addr,
	output snd_stream_pkg::frame_t                        frame,
	output logic                                          frame_valid,
	output logic                                          advance
);

	localparam int               idx_w    = $clog2(voice_count);
	localparam logic [idx_w-1:0] last_idx = idx_w'(voice_count - 1);

	snd_stream_pkg::seq_state_e state;
	snd_stream_pkg::seq_state_e state_nxt;
	logic [idx_w-1:0]           idx;
	logic [idx_w-1:0]           idx_nxt;
	logic                       start;
	logic                       finish;
	logic [7:0]                 smp_q [voice_count];
	logic [3:0]                 amp_q [voice_count];

	if (voice_count < 2 || voice_count > snd_stream_pkg::max_voices) begin : g_bad_count
		$error("voice_count must be 2 to %0d", snd_stream_pkg::max_voices);
	end

	// closing cycle counts as busy since positions move at its edge
	assign start = en && (state == snd_stream_pkg::seq_off) && !advance;

	////////////////////
	// next state
	////////////////////

	always_comb begin
		state_nxt = state;
		idx_nxt   = idx;
		finish    = 1'b0;
		case (state)
			snd_stream_pkg::seq_off: begin
				if (start) begin
					state_nxt = snd_stream_pkg::seq_load;
					idx_nxt   = '0;
				end
			end
			snd_stream_pkg::seq_load: begin
				// rom_load doubles as the voice active flag
				if (rom_load) begin
					state_nxt = snd_stream_pkg::seq_wait;
				end else if (idx == last_idx) begin
					state_nxt = snd_stream_pkg::seq_off;
					finish    = 1'b1;
				end else begin
					idx_nxt = idx + 1'b1;
				end
			end
			snd_stream_pkg::seq_wait: begin
				if (rom_ready)
					state_nxt = snd_stream_pkg::seq_valid;
			end
			snd_stream_pkg::seq_valid: begin
				if (idx == last_idx) begin
					state_nxt = snd_stream_pkg::seq_off;
					finish    = 1'b1;
				end else begin
					state_nxt = snd_stream_pkg::seq_load;
					idx_nxt   = idx + 1'b1;
				end
			end
			default: state_nxt = snd_stream_pkg::seq_off;
		endcase
	end

	////////////////////
	// control regs
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state       <= snd_stream_pkg::seq_off;
			idx         <= '0;
			rom_load    <= 1'b0;
			frame_valid <= 1'b0;
			advance     <= 1'b0;
		end else begin
			state       <= state_nxt;
			idx         <= idx_nxt;
			// pulse only for voices with something to play
			rom_load    <= (state_nxt == snd_stream_pkg::seq_load) && voices[idx_nxt].active;
			frame_valid <= finish;
			advance     <= finish;
		end
	end

	// address set up on entry to seq_load and held through seq_wait
	always_ff @(posedge clk) begin
		if (state_nxt == snd_stream_pkg::seq_load)
			rom_addr <= voices[idx_nxt].addr;
	end

	////////////////////
	// frame assembly
	////////////////////

	always_ff @(posedge clk) begin
		if (state == snd_stream_pkg::seq_wait && rom_ready) begin
			smp_q[idx] <= rom_data;
			amp_q[idx] <= voices[idx].amp;
		end else if (state == snd_stream_pkg::seq_load && !rom_load) begin
			// skipped voice is silent
			smp_q[idx] <= '0;
			amp_q[idx] <= '0;
		end
	end

	// slots past voice_count stay zero
	always_comb begin
		frame = '0;
		for (int v = 0; v < voice_count; v++) begin
			frame.sample[v] = smp_q[v];
			frame.amp[v]    = amp_q[v];
		end
	end

	////////////////////
	// checks
	////////////////////

	a_load_in_load: assert property (@(posedge clk) disable iff (!rst)
		rom_load |-> (state == snd_stream_pkg::seq_load));

	// rom sees one address per access
	a_addr_hold: assert property (@(posedge clk) disable iff (!rst)
		(state == snd_stream_pkg::seq_wait) |-> $stable(rom_addr));

endmodule

// File: logic/snd_map_pkg.sv
package snd_map_pkg;

	////////////////////
	// cpu register map
	////////////////////

	// select bus width for 8 voices of 4 fields
	localparam int select_w = 7;

	// registers per voice
	// select = voice * field_stride + field
	localparam logic [select_w-1:0] field_stride = 7'd4;

	// field offset inside one voice block
	typedef enum logic [1:0] {
		// low half of the start address
		field_addr_lo = 2'd0,
		// top byte of the start address in bits 7..0
		field_addr_hi = 2'd1,
		// amplitude in bits 3..0
		field_amp     = 2'd2,
		// length in samples
		// writing it also restarts the voice
		field_len     = 2'd3
	} reg_field_e;

	////////////////////
	// voice settings
	////////////////////

	// one voice as the cpu set it up
	typedef struct packed {
		// first rom byte of the sound
		logic [23:0] start;
		// unsigned gain
		logic [3:0]  amp;
		// zero means voice off
		logic [15:0] len;
	} voice_cfg_t;

endpackage

// File: logic/snd_stream_pkg.sv
package snd_stream_pkg;

	// upper bound on voice slots in a frame
	localparam int max_voices = 8;

	////////////////////
	// regs to sequencer
	////////////////////

	// per voice fetch request, held as a level
	typedef struct packed {
		// len nonzero and not finished
		logic        active;
		// start plus play position
		logic [23:0] addr;
		// gain to carry into the frame
		logic [3:0]  amp;
	} voice_fetch_t;

	////////////////////
	// sequencer to mixer
	////////////////////

	// one sample tick worth of voice data
	// unused slots read as zero
	typedef struct packed {
		// signed rom bytes
		logic [max_voices-1:0][7:0] sample;
		// unsigned gains
		logic [max_voices-1:0][3:0] amp;
	} frame_t;

	// fetch fsm
	typedef enum logic [1:0] {
		// idle until en
		seq_off   = 2'd0,
		// rom_load pulse or skip of an idle voice
		seq_load  = 2'd1,
		// rom busy until rom_ready
		seq_wait  = 2'd2,
		// step to next voice or close the frame
		seq_valid = 2'd3
	} seq_state_e;

endpackage

// File: logic/sound_core.sv
`timescale 1ns/1ps

module sound_core #(
	parameter int voice_count = 4
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             en,
	// cpu register port
	input  logic                             mem_en,
	input  logic                             memwrite,
	input  logic [15:0]                      writedata,
	input  logic [snd_map_pkg::select_w-1:0] select,
	// sample rom
	input  logic [7:0]                       rom_data,
	input  logic                             rom_ready,
	output logic                             rom_load,
	output logic [23:0]                      rom_addr,
	// mixed output
	output logic signed [15:0]               mix_sample,
	output logic                             mix_valid
);

	snd_stream_pkg::voice_fetch_t [voice_count-1:0] voices;
	snd_stream_pkg::frame_t                         frame;
	logic                                           frame_valid;
	logic                                           advance;

	// settings and play positions
	voice_regs #(.voice_count(voice_count)) regs0 (
		.clk       (clk),
		.rst       (rst),
		.mem_en    (mem_en),
		.memwrite  (memwrite),
		.writedata (writedata),
		.select    (select),
		.advance   (advance),
		.voices    (voices)
	);

	// one rom walk per tick
	fetch_sequencer #(.voice_count(voice_count)) seq0 (
		.clk         (clk),
		.rst         (rst),
		.en          (en),
		.voices      (voices),
		.rom_data    (rom_data),
		.rom_ready   (rom_ready),
		.rom_load    (rom_load),
		.rom_addr    (rom_addr),
		.frame       (frame),
		.frame_valid (frame_valid),
		.advance     (advance)
	);

	// scale and sum
	voice_mixer #(.voice_count(voice_count)) mix0 (
		.clk         (clk),
		.rst         (rst),
		.frame       (frame),
		.frame_valid (frame_valid),
		.mix_sample  (mix_sample),
		.mix_valid   (mix_valid)
	);

endmodule

// File: logic/voice_mixer.sv
`timescale 1ns/1ps

module voice_mixer #(
	parameter int voice_count = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  snd_stream_pkg::frame_t frame,
	input  logic                   frame_valid,
	output logic signed [15:0]     mix_sample,
	output logic                   mix_valid
);

	// 8 bit signed times 5 bit zero-extended gain
	logic signed [12:0] prod_d [voice_count];
	logic signed [12:0] prod_q [voice_count];
	logic               prod_valid;
	logic signed [15:0] sum_d;

	////////////////////
	// stage one
	////////////////////

	// unsigned gain gets a zero sign bit
	always_comb begin
		for (int v = 0; v < voice_count; v++) begin
			prod_d[v] = $signed(frame.sample[v]) * $signed({1'b0, frame.amp[v]});
		end
	end

	always_ff @(posedge clk) begin
		if (frame_valid)
			prod_q <= prod_d;
	end

	always_ff @(posedge clk) begin
		if (!rst)
			prod_valid <= 1'b0;
		else
			prod_valid <= frame_valid;
	end

	////////////////////
	// stage two
	////////////////////

	// worst case 8 * 128 * 15 fits in 16 bits
	always_comb begin
		sum_d = '0;
		for (int v = 0; v < voice_count; v++) begin
			sum_d = sum_d + prod_q[v];
		end
	end

	// output holds until the next frame lands
	always_ff @(posedge clk) begin
		if (!rst) begin
			mix_sample <= '0;
			mix_valid  <= 1'b0;
		end else begin
			mix_valid <= prod_valid;
			if (prod_valid)
				mix_sample <= sum_d;
		end
	end

	////////////////////
	// checks
	////////////////////

	// fixed two cycle pipe
	a_mix_latency: assert property (@(posedge clk) disable iff (!rst)
		mix_valid |-> $past(frame_valid, 2));

endmodule

// File: logic/voice_regs.sv
`timescale 1ns/1ps

module voice_regs #(
	parameter int voice_count = 4
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          mem_en,
	input  logic                                          memwrite,
	input  logic [15:0]                                   writedata,
	input  logic [snd_map_pkg::select_w-1:0]              select,
	input  logic                                          advance,
	output snd_stream_pkg::voice_fetch_t [voice_count-1:0] voices
);

	localparam int sel_w = snd_map_pkg::select_w;

	logic                    wr_hit;
	logic [sel_w-1:0]        wr_voice;
	logic [sel_w-1:0]        field_raw;
	snd_map_pkg::reg_field_e wr_field;

	////////////////////
	// write decode
	////////////////////

	// selects past the last voice fall through
	assign wr_hit = mem_en && memwrite && (select < voice_count * snd_map_pkg::field_stride);

	// split select into voice and field
	assign wr_voice  = select / snd_map_pkg::field_stride;
	assign field_raw = select % snd_map_pkg::field_stride;
	assign wr_field  = snd_map_pkg::reg_field_e'(field_raw[1:0]);

	////////////////////
	// voice slots
	////////////////////

	for (genvar i = 0; i < voice_count; i++) begin : g_voice
		// voice 0 is the background loop
		localparam bit looping = (i == 0);

		snd_map_pkg::voice_cfg_t cfg;
		logic [15:0]             pos;
		logic                    done;
		logic                    active;
		logic                    sel_me;
		logic                    restart;
		logic                    at_end;

		assign sel_me  = wr_hit && (wr_voice == sel_w'(i));
		assign restart = sel_me && (wr_field == snd_map_pkg::field_len);

		// last sample of the sound is playing
		assign at_end = (pos == cfg.len - 16'd1);

		// one-shot voices drop out once done is set
		assign active = (cfg.len != 16'd0) && !done;

		always_ff @(posedge clk) begin
			if (!rst) begin
				cfg.len <= '0;
				pos     <= '0;
				done    <= 1'b0;
			end else begin
				// cpu side
				if (sel_me) begin
					case (wr_field)
						snd_map_pkg::field_addr_lo: cfg.start[15:0]  <= writedata;
						snd_map_pkg::field_addr_hi: cfg.start[23:16] <= writedata[7:0];
						snd_map_pkg::field_amp:     cfg.amp          <= writedata[3:0];
						snd_map_pkg::field_len:     cfg.len          <= writedata;
						default: ;
					endcase
				end

				// new length wins over a same cycle advance
				if (restart) begin
					pos  <= '0;
					done <= 1'b0;
				end else if (advance && active) begin
					if (!at_end)
						pos <= pos + 16'd1;
					else if (looping)
						pos <= '0;
					else
						done <= 1'b1;
				end
			end
		end

		// rom address of the current sample
		assign voices[i] = '{
			active: active,
			addr:   cfg.start + 24'(pos),
			amp:    cfg.amp
		};
	end

	////////////////////
	// checks
	////////////////////

	// sequencer closes at most one frame per cycle pair
	a_advance_single: assert property (@(posedge clk) disable iff (!rst)
		advance |=> !advance);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sound_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module sound_core_tb \
	-f flist.f \
	-o sound_sim

./obj_dir/sound_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation reported errors, see sim.log"
	exit 1
fi
echo "simulation finished without errors"

// File: verification/sound_cases.txt
# W sel data : register write, select and data in hex
# T mix : one tick, expected mix_sample in hex, B mix : tick with a dropped second en
# idle engine after reset
T 0000
# voice 0 loop at 051240, amp 3, len 3
W 00 1240
W 01 0005
W 02 0003
W 03 0003
T 00f6
T 00f9
T 00f0
T 00f6
# voice 0 off, voice 1 one-shot at 0010f0, amp 2, len 2
W 03 0000
W 04 10f0
W 05 0000
W 06 0002
W 07 0002
T ffc0
T ffc2
T 0000
T 0000
# rewriting the length restarts the effect
W 07 0002
T ffc0
# select 16 is past voice 3 and ignored
W 10 0003
# voice 2 at 003377 amp 4 len 5, voice 3 at 007fff amp 15 len 2
W 08 3377
W 09 0000
W 0a 0004
W 0b 0005
W 0c 7fff
W 0d 0000
W 0e 000f
W 0f 0002
W 07 0002
W 03 0004
# -1466, -1433, 536, 535, 534
T fa46
T fa67
T 0218
T 0217
T 0216
# second en during a busy frame
B 00f9
T 00f0
# everything quiet again
W 03 0000
T 0000

// File: verification/sound_core_tb.sv
`timescale 1ns/1ps

module sound_core_tb;

	localparam int voice_count = 4;

	logic                             clk = 1'b0;
	logic                             rst;
	logic                             en;
	logic                             mem_en;
	logic                             memwrite;
	logic [15:0]                      writedata;
	logic [snd_map_pkg::select_w-1:0] select;
	logic [7:0]                       rom_data = 8'h00;
	logic                             rom_ready = 1'b0;
	logic                             rom_load;
	logic [23:0]                      rom_addr;
	logic signed [15:0]               mix_sample;
	logic                             mix_valid;

	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     loads = 0;
	int     mixes = 0;
	int     lat_left = 0;
	bit     fixed_lat = 1'b0;
	bit     loaded = 1'b0;

	// parsed case lines as kind char plus two args
	int          case_kind [$];
	logic [15:0] case_a [$];
	logic [15:0] case_b [$];

	// voice state as the register map describes it
	logic [23:0] m_start [voice_count];
	logic [15:0] m_len [voice_count];
	logic [15:0] m_pos [voice_count];
	logic        m_done [voice_count];
	// rom addresses due in the running tick
	logic [23:0] exp_addr [$];

	sound_core #(.voice_count(voice_count)) dut0 (
		.clk        (clk),
		.rst        (rst),
		.en         (en),
		.mem_en     (mem_en),
		.memwrite   (memwrite),
		.writedata  (writedata),
		.select     (select),
		.rom_data   (rom_data),
		.rom_ready  (rom_ready),
		.rom_load   (rom_load),
		.rom_addr   (rom_addr),
		.mix_sample (mix_sample),
		.mix_valid  (mix_valid)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	////////////////////
	// rom model
	////////////////////

	// byte is addr[7:0] ^ addr[15:8]
	// ready 1 to 4 cycles after the load
	always @(negedge clk) begin
		rom_ready = 1'b0;
		if (mix_valid)
			mixes++;
		if (rom_load) begin
			loads++;
			if (exp_addr.size() == 0) begin
				errors++;
				$display("rom_load pulse with no active voice left to fetch");
			end else begin
				check_value("rom_addr", rom_addr, exp_addr.pop_front());
			end
			lat_left = fixed_lat ? 4 : 1 + ($unsigned($random(seed)) % 4);
		end else if (lat_left > 0) begin
			lat_left--;
			if (lat_left == 0) begin
				rom_ready = 1'b1;
				rom_data  = rom_addr[7:0] ^ rom_addr[15:8];
			end
		end
	end

	////////////////////
	// voice model
	////////////////////

	function automatic void model_write(input logic [15:0] sel, input logic [15:0] data);
		int v;
		v = sel / 4;
		// past the last voice nothing changes
		if (sel < voice_count * 4) begin
			case (sel % 4)
				0: m_start[v][15:0] = data;
				1: m_start[v][23:16] = data[7:0];
				3: begin
					m_len[v]  = data;
					m_pos[v]  = '0;
					m_done[v] = 1'b0;
				end
				// amp only shapes the mix
				default: ;
			endcase
		end
	endfunction

	// push one address per active voice and return how many
	function automatic int queue_addresses();
		int n;
		n = 0;
		for (int v = 0; v < voice_count; v++) begin
			if (m_len[v] != 16'd0 && !m_done[v]) begin
				exp_addr.push_back(m_start[v] + 24'(m_pos[v]));
				n++;
			end
		end
		return n;
	endfunction

	// voice 0 loops and the others stop after the last sample
	function automatic void model_advance();
		for (int v = 0; v < voice_count; v++) begin
			if (m_len[v] != 16'd0 && !m_done[v]) begin
				if (m_pos[v] != m_len[v] - 16'd1)
					m_pos[v] = m_pos[v] + 16'd1;
				else if (v == 0)
					m_pos[v] = '0;
				else
					m_done[v] = 1'b1;
			end
		end
	endfunction

	////////////////////
	// stimulus
	////////////////////

	task automatic reg_write(input logic [15:0] sel, input logic [15:0] data);
		@(negedge clk);
		mem_en    = 1'b1;
		memwrite  = 1'b1;
		select    = sel[snd_map_pkg::select_w-1:0];
		writedata = data;
		@(negedge clk);
		mem_en   = 1'b0;
		memwrite = 1'b0;
		model_write(sel, data);
	endtask

	// busy adds a second en mid frame under a fixed 4 cycle rom
	task automatic run_tick(input logic [15:0] expected, input bit busy);
		int load_base;
		int mix_base;
		int want_loads;
		load_base  = loads;
		mix_base   = mixes;
		want_loads = queue_addresses();
		fixed_lat  = busy;
		@(negedge clk);
		en = 1'b1;
		@(negedge clk);
		en = 1'b0;
		if (busy) begin
			// lands while the first voice waits on the rom
			repeat (2) @(negedge clk);
			en = 1'b1;
			@(negedge clk);
			en = 1'b0;
		end
		do @(negedge clk); while (!mix_valid);
		check_value("mix_sample", {16'h0000, mix_sample}, {16'h0000, expected});
		@(negedge clk);
		// room for a frame that should never start
		if (busy)
			repeat (40) @(negedge clk);
		check_value("rom_load count", loads - load_base, want_loads);
		check_value("mix_valid count", mixes - mix_base, 1);
		model_advance();
	endtask

	task automatic load_cases();
		int          fd;
		int          c;
		int          n;
		logic [15:0] a;
		logic [15:0] b;
		fd = $fopen("verification/sound_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open verification/sound_cases.txt");
		end else begin
			c = $fgetc(fd);
			while (c != -1) begin
				if (c == "#") begin
					while (c != -1 && c != "\n")
						c = $fgetc(fd);
				end else if (c == "W" || c == "T" || c == "B") begin
					b = '0;
					if (c == "W")
						n = $fscanf(fd, "%h %h", a, b) - 1;
					else
						n = $fscanf(fd, "%h", a);
					if (n != 1) begin
						errors++;
						$display("malformed line in the case file");
					end
					case_kind.push_back(c);
					case_a.push_back(a);
					case_b.push_back(b);
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	initial begin
		rst       = 1'b0;
		en        = 1'b0;
		mem_en    = 1'b0;
		memwrite  = 1'b0;
		writedata = '0;
		select    = '0;
		seed      = 32'h3998_fc54;
		for (int v = 0; v < voice_count; v++) begin
			m_start[v] = '0;
			m_len[v]   = '0;
			m_pos[v]   = '0;
			m_done[v]  = 1'b0;
		end
		load_cases();
		loaded = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < case_kind.size(); i++) begin
			if (case_kind[i] == "W")
				reg_write(case_a[i], case_b[i]);
			else
				run_tick(case_a[i], case_kind[i] == "B");
		end
		@(negedge clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// limit scales with the case count
	initial begin
		wait (loaded);
		repeat ((case_kind.size() + 1) * 200) @(posedge clk);
		$display("timeout, a tick never produced mix_valid in time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
